//--- layer_blender.f
+incdir+src
src/video_pkg.sv
src/cfg_pkg.sv
src/layer_cfg_regs.sv
src/window_shifter.sv
src/alpha_blender.sv
src/blender_top.sv
sim/clk_gen.sv
sim/blender_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module blender_tb -f layer_blender.f

# Output goes to the terminal through stderr, the grep decides the exit status
./obj_dir/Vblender_tb | tee /dev/stderr | grep "^sim passed$" > /dev/null
echo "Run OK"

//--- sim/blender_tb.sv
`timescale 1ns/1ps
`include "blender_defs.svh"

module blender_tb;

	localparam int TIMEOUT_CYCLES = 6000;
	localparam int BEAT_W         = `BG_PIXEL_WIDTH + 2;
	localparam int MAX_BEATS      = 128;

	logic                       clk;
	logic                       resetn;
	logic                       cfg_we;
	cfg_pkg::cfg_reg_e          cfg_addr;
	logic [`CFG_DATA_WIDTH-1:0] cfg_wdata;
	logic                       m_valid;
	logic                       m_ready;
	video_pkg::out_beat_t       m_beat;

	// Layer sources, index 0 is the background
	logic              src_valid [3];
	logic [BEAT_W-1:0] src_beat  [3];
	logic              src_ready [3];
	logic [BEAT_W-1:0] src_mem   [3][MAX_BEATS];
	int                src_len   [3];

	video_pkg::out_beat_t exp_q[$];

	// Model of the register contents
	int out_w;
	int out_h;
	bit order;
	int win_left   [3];
	int win_top    [3];
	int win_width  [3];
	int win_height [3];

	int seed;
	int err_count;
	int test_errs;
	int cycle_count;

	clk_gen u_clk (
		.clk    (clk),
		.resetn (resetn)
	);

	blender_top UUT (
		.clk       (clk),
		.resetn    (resetn),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.bg_valid  (src_valid[0]),
		.bg_beat   (src_beat[0]),
		.bg_ready  (src_ready[0]),
		.ov1_valid (src_valid[1]),
		.ov1_beat  (src_beat[1][`OV_PIXEL_WIDTH+1:0]),
		.ov1_ready (src_ready[1]),
		.ov2_valid (src_valid[2]),
		.ov2_beat  (src_beat[2][`OV_PIXEL_WIDTH+1:0]),
		.ov2_ready (src_ready[2]),
		.m_valid   (m_valid),
		.m_beat    (m_beat),
		.m_ready   (m_ready)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic wait_clk();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [7:0] rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic int rand_pct();
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % 100;
	endfunction

	task automatic write_reg(input cfg_pkg::cfg_reg_e addr, input int lo, input int hi);
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = (32'(hi) << `CFG_HI_LSB) | 32'(lo);
		wait_clk();
		cfg_we = 1'b0;
	endtask

	task automatic set_win(input int k, input int l, input int t, input int w, input int h);
		cfg_pkg::cfg_reg_e pos_reg;
		cfg_pkg::cfg_reg_e size_reg;
		case (k)
			0: begin
				pos_reg  = cfg_pkg::CFG_WIN0_POS;
				size_reg = cfg_pkg::CFG_WIN0_SIZE;
			end
			1: begin
				pos_reg  = cfg_pkg::CFG_WIN1_POS;
				size_reg = cfg_pkg::CFG_WIN1_SIZE;
			end
			default: begin
				pos_reg  = cfg_pkg::CFG_WIN2_POS;
				size_reg = cfg_pkg::CFG_WIN2_SIZE;
			end
		endcase
		win_left[k]   = l;
		win_top[k]    = t;
		win_width[k]  = w;
		win_height[k] = h;
		write_reg(pos_reg, l, t);
		write_reg(size_reg, w, h);
	endtask

	task automatic set_out_size(input int w, input int h);
		out_w = w;
		out_h = h;
		write_reg(cfg_pkg::CFG_OUT_SIZE, w, h);
	endtask

	task automatic set_order(input int o);
		order = (o != 0);
		write_reg(cfg_pkg::CFG_ORDER, o, 0);
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic bit covers(input int k, input int c, input int r);
		return (c >= win_left[k]) && (c < win_left[k] + win_width[k])
			&& (r >= win_top[k]) && (r < win_top[k] + win_height[k]);
	endfunction

	// Result keeps alpha/256 of the gap between the channel and the grey value
	function automatic logic [23:0] expected_rgb(input logic [31:0] bg, input int grey,
		input bit has_ov);
		int          alpha;
		int          a;
		int          m;
		int          i;
		logic [23:0] rgb;
		alpha = int'(bg[31:24]);
		for (i = 0; i < 3; i++) begin
			a = int'(bg[i*8 +: 8]);
			if (!has_ov) begin
				m = a;
			end else if (a > grey) begin
				m = grey + (((a - grey) * alpha) >> 8);
			end else begin
				m = grey - (((grey - a) * alpha) >> 8);
			end
			rgb[i*8 +: 8] = m[7:0];
		end
		return rgb;
	endfunction

	task automatic add_beat(input int k, input logic [31:0] data, input int c, input int r);
		logic user;
		logic last;
		user = (c == win_left[k]) && (r == win_top[k]);
		last = (c == win_left[k] + win_width[k] - 1);
		src_mem[k][src_len[k]] = {data, user, last};
		src_len[k]++;
	endtask

	// One frame of stream beats and the output beats that must come back
	task automatic build_frame();
		int                   r;
		int                   c;
		int                   k;
		logic [31:0]          px;
		logic [7:0]           ov [3];
		bit                   in_win [3];
		bit                   has_ov;
		int                   grey;
		video_pkg::out_beat_t exp;
		for (r = 0; r < out_h; r++) begin
			for (c = 0; c < out_w; c++) begin
				// Alpha cycles through transparent, opaque and random
				case ((r * out_w + c) % 3)
					0: px[31:24] = 8'h00;
					1: px[31:24] = 8'hff;
					default: px[31:24] = rand_byte();
				endcase
				px[23:0] = {rand_byte(), rand_byte(), rand_byte()};
				for (k = 0; k < 3; k++) begin
					in_win[k] = covers(k, c, r);
					ov[k]     = rand_byte();
					if (in_win[k]) begin
						add_beat(k, (k == 0) ? px : {24'h0, ov[k]}, c, r);
					end
				end
				if (!in_win[0]) begin
					px = '0;
				end
				has_ov = in_win[1] || in_win[2];
				if (order) begin
					grey = in_win[1] ? int'(ov[1]) : int'(ov[2]);
				end else begin
					grey = in_win[2] ? int'(ov[2]) : int'(ov[1]);
				end
				exp.data = expected_rgb(px, grey, has_ov);
				exp.user = (c == 0) && (r == 0);
				exp.last = (c == out_w - 1);
				exp_q.push_back(exp);
			end
		end
	endtask

	//////////////////////////////
	// Stream drivers
	//////////////////////////////

	task automatic feed_layer(input int k, input int gap);
		int i;
		bit xfer;
		i = 0;
		while (i < src_len[k]) begin
			if (!src_valid[k] && rand_pct() >= gap) begin
				src_beat[k]  = src_mem[k][i];
				src_valid[k] = 1'b1;
			end
			@(negedge clk);
			xfer = src_valid[k] && src_ready[k];
			wait_clk();
			if (xfer) begin
				src_valid[k] = 1'b0;
				i++;
			end
		end
	endtask

	task automatic collect_output(input string name, input int gap);
		video_pkg::out_beat_t exp;
		int                   idx;
		bit                   xfer;
		idx = 0;
		while (exp_q.size() > 0) begin
			m_ready = (rand_pct() >= gap);
			@(negedge clk);
			xfer = m_valid && m_ready;
			if (xfer) begin
				exp = exp_q.pop_front();
				if (m_beat !== exp) begin
					$display("ERR %s: beat %0d expected %h actual %h", name, idx, exp, m_beat);
					test_errs++;
				end
				idx++;
			end
			wait_clk();
		end
		m_ready = 1'b0;
	endtask

	task automatic run_frames(input string name, input int frames, input int in_gap,
		input int out_gap);
		for (int k = 0; k < 3; k++) begin
			src_len[k] = 0;
		end
		exp_q.delete();
		repeat (frames) build_frame();
		fork
			feed_layer(0, in_gap);
			feed_layer(1, in_gap);
			feed_layer(2, in_gap);
			collect_output(name, out_gap);
		join
		// Raster is back at the origin and waits for layer 0
		if (m_valid) begin
			$display("%s: an output beat appeared after the last pixel of the frame", name);
			test_errs++;
		end
	endtask

	task automatic report_test(input string name);
		$display("%s: %0d errors", name, test_errs);
		err_count += test_errs;
	endtask

	// Outputs after the first clock edge with reset held
	task automatic check_reset_outputs();
		wait_clk();
		if (m_valid !== 1'b0 || src_ready[0] !== 1'b0 || src_ready[1] !== 1'b0
			|| src_ready[2] !== 1'b0) begin
			$display("Valid or ready outputs were not low during reset");
			err_count++;
		end
	endtask

	// With every window empty the raster free-runs out of reset
	task automatic align_raster();
		m_ready = 1'b0;
		while (!m_valid) begin
			wait_clk();
		end
		m_ready = 1'b1;
		repeat (`RST_OUT_WIDTH * `RST_OUT_HEIGHT - 1) @(posedge clk);
		#1;
		m_ready = 1'b0;
		if (!m_valid || !m_beat.last || m_beat.user) begin
			$display("Raster did not stop on the last pixel of the reset frame");
			err_count++;
		end
		set_win(0, 0, 0, `RST_OUT_WIDTH, `RST_OUT_HEIGHT);
		// Drop the parked beat, then layer 0 gates the raster
		m_ready = 1'b1;
		wait_clk();
		m_ready = 1'b0;
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic bg_passthrough();
		test_errs = 0;
		set_win(1, 0, 0, 0, 0);
		set_win(2, 0, 0, 0, 0);
		run_frames("bg_passthrough", 1, 0, 0);
		report_test("bg_passthrough");
	endtask

	task automatic single_overlay();
		test_errs = 0;
		set_win(1, 2, 1, 3, 2);
		run_frames("single_overlay", 1, 0, 0);
		report_test("single_overlay");
	endtask

	task automatic overlap_order();
		test_errs = 0;
		set_win(1, 1, 1, 4, 3);
		set_win(2, 3, 2, 5, 3);
		set_order(0);
		run_frames("overlap_order", 1, 0, 0);
		set_order(1);
		run_frames("overlap_order", 1, 0, 0);
		report_test("overlap_order");
	endtask

	task automatic output_backpressure();
		test_errs = 0;
		run_frames("output_backpressure", 1, 0, 50);
		report_test("output_backpressure");
	endtask

	task automatic input_stalls();
		test_errs = 0;
		run_frames("input_stalls", 2, 40, 0);
		report_test("input_stalls");
	endtask

	task automatic frame_rewrite();
		test_errs = 0;
		set_out_size(5, 4);
		set_win(0, 0, 0, 5, 4);
		set_win(1, 3, 2, 2, 2);
		set_win(2, 0, 0, 2, 1);
		run_frames("frame_rewrite", 1, 20, 20);
		report_test("frame_rewrite");
	endtask

	//////////////////////////////
	// Run control
	//////////////////////////////

	initial begin
		seed      = 32'hff02_2783;
		err_count = 0;
		test_errs = 0;
		cfg_we    = 1'b0;
		cfg_addr  = cfg_pkg::CFG_OUT_SIZE;
		cfg_wdata = '0;
		m_ready   = 1'b0;
		out_w     = `RST_OUT_WIDTH;
		out_h     = `RST_OUT_HEIGHT;
		order     = 1'b0;
		for (int k = 0; k < 3; k++) begin
			src_valid[k]  = 1'b0;
			src_beat[k]   = '0;
			src_len[k]    = 0;
			win_left[k]   = 0;
			win_top[k]    = 0;
			win_width[k]  = 0;
			win_height[k] = 0;
		end
		check_reset_outputs();
		wait (resetn === 1'b1);
		wait_clk();
		align_raster();
		bg_passthrough();
		single_overlay();
		overlap_order();
		output_backpressure();
		input_stalls();
		frame_rewrite();
		$display("6 tests, %0d errors", err_count);
		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Six tests of about 48 pixels each, with wide room for stalls
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the DUT stopped moving pixels", cycle_count);
		$display("sim failed");
		$finish;
	end

endmodule

//--- sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic resetn
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Release just after a rising edge, like the other testbench drives
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		resetn = 1'b1;
	end

endmodule

//--- src/alpha_blender.sv
`timescale 1ns/1ps
`include "blender_defs.svh"

module alpha_blender (
	input  logic                       clk,
	input  logic                       resetn,
	input  cfg_pkg::cfg_t              cfg,
	input  logic                       need0,
	input  logic                       need1,
	input  logic                       need2,
	input  logic                       valid0,
	input  logic                       valid1,
	input  logic                       valid2,
	input  logic [`BG_PIXEL_WIDTH-1:0] data0,
	input  logic [`OV_PIXEL_WIDTH-1:0] data1,
	input  logic [`OV_PIXEL_WIDTH-1:0] data2,
	output logic [`IMG_WBITS-1:0]      col,
	output logic [`IMG_HBITS-1:0]      row,
	output logic                       advance,
	output video_pkg::out_beat_t       m_beat,
	output logic                       m_valid,
	input  logic                       m_ready
);

	localparam int CHANNELS = `OUT_PIXEL_WIDTH / 8;

	// Mix background channel a toward grey b, weighted by alpha
	function automatic logic [7:0] mix(
		input logic [7:0] a,
		input logic [7:0] b,
		input logic [7:0] alpha
	);
		logic [15:0] prod;
		if (a > b) begin
			prod = 16'(a - b) * 16'(alpha);
			mix  = b + prod[15:8];
		end else begin
			prod = 16'(b - a) * 16'(alpha);
			mix  = b - prod[15:8];
		end
	endfunction

	logic                        out_free;
	logic                        has_ov;
	logic [`OV_PIXEL_WIDTH-1:0]  ov_sel;
	logic [7:0]                  grey;
	logic [7:0]                  alpha;
	logic [`OUT_PIXEL_WIDTH-1:0] blend;
	logic                        frame_first;
	logic                        line_last;

	//////////////////////////////
	// Step condition
	//////////////////////////////

	assign out_free = !m_valid || m_ready;
	assign advance  = (!need0 || valid0)
		&& (!need1 || valid1)
		&& (!need2 || valid2)
		&& out_free;

	//////////////////////////////
	// Raster position
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			col <= '0;
			row <= '0;
		end else if (advance) begin
			if (col != cfg.out_width - 1'b1) begin
				col <= col + 1'b1;
			end else begin
				col <= '0;
				row <= (row == cfg.out_height - 1'b1) ? '0 : row + 1'b1;
			end
		end
	end

	assign frame_first = (col == '0) && (row == '0);
	assign line_last   = (col == cfg.out_width - 1'b1);

	//////////////////////////////
	// Layer join and blend
	//////////////////////////////

	// Order bit picks the overlay that wins where both cover the pixel
	assign ov_sel = cfg.order_1over2 ? (need1 ? data1 : data2)
		: (need2 ? data2 : data1);
	assign grey   = ov_sel[`OV_PIXEL_WIDTH-1 -: 8];
	assign alpha  = data0[`BG_PIXEL_WIDTH-1 -: 8];
	assign has_ov = need1 || need2;

	always_comb begin
		for (int i = 0; i < CHANNELS; i++) begin
			if (has_ov) begin
				blend[i*8 +: 8] = mix(data0[i*8 +: 8], grey, alpha);
			end else begin
				blend[i*8 +: 8] = data0[i*8 +: 8];
			end
		end
	end

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			m_valid <= 1'b0;
		end else if (advance) begin
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			m_beat.data <= blend;
			m_beat.user <= frame_first;
			m_beat.last <= line_last;
		end
	end

	// Held output beat stays put under back-pressure
	assert property (@(posedge clk) disable iff (!resetn)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_beat)));

endmodule

//--- src/blender_defs.svh
`ifndef BLENDER_DEFS_SVH
`define BLENDER_DEFS_SVH

// Raster index widths
`define IMG_WBITS 12
`define IMG_HBITS 12

// Pixel widths per layer
`define BG_PIXEL_WIDTH 32
`define OV_PIXEL_WIDTH 8
`define OUT_PIXEL_WIDTH 24

// Register write word and its upper field
`define CFG_DATA_WIDTH 32
`define CFG_HI_LSB 16

// Output size out of reset
`define RST_OUT_WIDTH 8
`define RST_OUT_HEIGHT 6

`endif

//--- src/blender_top.sv
`timescale 1ns/1ps
`include "blender_defs.svh"

module blender_top (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       cfg_we,
	input  cfg_pkg::cfg_reg_e          cfg_addr,
	input  logic [`CFG_DATA_WIDTH-1:0] cfg_wdata,
	input  logic                       bg_valid,
	input  video_pkg::bg_beat_t        bg_beat,
	output logic                       bg_ready,
	input  logic                       ov1_valid,
	input  video_pkg::ov_beat_t        ov1_beat,
	output logic                       ov1_ready,
	input  logic                       ov2_valid,
	input  video_pkg::ov_beat_t        ov2_beat,
	output logic                       ov2_ready,
	output logic                       m_valid,
	output video_pkg::out_beat_t       m_beat,
	input  logic                       m_ready
);

	cfg_pkg::cfg_t              cfg;
	logic [`IMG_WBITS-1:0]      col;
	logic [`IMG_HBITS-1:0]      row;
	logic                       advance;
	logic                       need0;
	logic                       need1;
	logic                       need2;
	logic                       valid0;
	logic                       valid1;
	logic                       valid2;
	logic [`BG_PIXEL_WIDTH-1:0] data0;
	logic [`OV_PIXEL_WIDTH-1:0] data1;
	logic [`OV_PIXEL_WIDTH-1:0] data2;

	layer_cfg_regs u_regs (
		.clk       (clk),
		.resetn    (resetn),
		.cfg_we    (cfg_we),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg       (cfg)
	);

	//////////////////////////////
	// Layer gates
	//////////////////////////////

	window_shifter #(.PIXEL_WIDTH(`BG_PIXEL_WIDTH)) u_shift0 (
		.clk        (clk),
		.resetn     (resetn),
		.col        (col),
		.row        (row),
		.advance    (advance),
		.win        (cfg.win0),
		.s_valid    (bg_valid),
		.s_data     (bg_beat.data),
		.s_user     (bg_beat.user),
		.s_last     (bg_beat.last),
		.s_ready    (bg_ready),
		.need       (need0),
		.hold_valid (valid0),
		.data       (data0)
	);

	window_shifter #(.PIXEL_WIDTH(`OV_PIXEL_WIDTH)) u_shift1 (
		.clk        (clk),
		.resetn     (resetn),
		.col        (col),
		.row        (row),
		.advance    (advance),
		.win        (cfg.win1),
		.s_valid    (ov1_valid),
		.s_data     (ov1_beat.data),
		.s_user     (ov1_beat.user),
		.s_last     (ov1_beat.last),
		.s_ready    (ov1_ready),
		.need       (need1),
		.hold_valid (valid1),
		.data       (data1)
	);

	// Layer 2 takes its own stream
	window_shifter #(.PIXEL_WIDTH(`OV_PIXEL_WIDTH)) u_shift2 (
		.clk        (clk),
		.resetn     (resetn),
		.col        (col),
		.row        (row),
		.advance    (advance),
		.win        (cfg.win2),
		.s_valid    (ov2_valid),
		.s_data     (ov2_beat.data),
		.s_user     (ov2_beat.user),
		.s_last     (ov2_beat.last),
		.s_ready    (ov2_ready),
		.need       (need2),
		.hold_valid (valid2),
		.data       (data2)
	);

	alpha_blender u_blend (
		.clk     (clk),
		.resetn  (resetn),
		.cfg     (cfg),
		.need0   (need0),
		.need1   (need1),
		.need2   (need2),
		.valid0  (valid0),
		.valid1  (valid1),
		.valid2  (valid2),
		.data0   (data0),
		.data1   (data1),
		.data2   (data2),
		.col     (col),
		.row     (row),
		.advance (advance),
		.m_beat  (m_beat),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

endmodule

//--- src/cfg_pkg.sv
`include "blender_defs.svh"

package cfg_pkg;

	// Register map, one address per write word
	typedef enum logic [2:0] {
		CFG_OUT_SIZE  = 3'd0,
		CFG_ORDER     = 3'd1,
		CFG_WIN0_POS  = 3'd2,
		CFG_WIN0_SIZE = 3'd3,
		CFG_WIN1_POS  = 3'd4,
		CFG_WIN1_SIZE = 3'd5,
		CFG_WIN2_POS  = 3'd6,
		CFG_WIN2_SIZE = 3'd7
	} cfg_reg_e;

	// Full blender configuration
	typedef struct packed {
		logic [`IMG_WBITS-1:0] out_width;
		logic [`IMG_HBITS-1:0] out_height;
		logic                  order_1over2;
		video_pkg::win_t       win0;
		video_pkg::win_t       win1;
		video_pkg::win_t       win2;
	} cfg_t;

endpackage

//--- src/layer_cfg_regs.sv
`timescale 1ns/1ps
`include "blender_defs.svh"

module layer_cfg_regs (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       cfg_we,
	input  cfg_pkg::cfg_reg_e          cfg_addr,
	input  logic [`CFG_DATA_WIDTH-1:0] cfg_wdata,
	output cfg_pkg::cfg_t              cfg
);

	// Low field carries left or width, high field top or height
	logic [`IMG_WBITS-1:0] lo_field;
	logic [`IMG_HBITS-1:0] hi_field;

	assign lo_field = cfg_wdata[`IMG_WBITS-1:0];
	assign hi_field = cfg_wdata[`CFG_HI_LSB +: `IMG_HBITS];

	//////////////////////////////
	// Register file
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cfg.out_width    <= `IMG_WBITS'(`RST_OUT_WIDTH);
			cfg.out_height   <= `IMG_HBITS'(`RST_OUT_HEIGHT);
			cfg.order_1over2 <= 1'b0;
			cfg.win0         <= '0;
			cfg.win1         <= '0;
			cfg.win2         <= '0;
		end else if (cfg_we) begin
			case (cfg_addr)
				cfg_pkg::CFG_OUT_SIZE: begin
					cfg.out_width  <= lo_field;
					cfg.out_height <= hi_field;
				end
				cfg_pkg::CFG_ORDER: begin
					cfg.order_1over2 <= cfg_wdata[0];
				end
				cfg_pkg::CFG_WIN0_POS: begin
					cfg.win0.left <= lo_field;
					cfg.win0.top  <= hi_field;
				end
				cfg_pkg::CFG_WIN0_SIZE: begin
					cfg.win0.width  <= lo_field;
					cfg.win0.height <= hi_field;
				end
				cfg_pkg::CFG_WIN1_POS: begin
					cfg.win1.left <= lo_field;
					cfg.win1.top  <= hi_field;
				end
				cfg_pkg::CFG_WIN1_SIZE: begin
					cfg.win1.width  <= lo_field;
					cfg.win1.height <= hi_field;
				end
				cfg_pkg::CFG_WIN2_POS: begin
					cfg.win2.left <= lo_field;
					cfg.win2.top  <= hi_field;
				end
				cfg_pkg::CFG_WIN2_SIZE: begin
					cfg.win2.width  <= lo_field;
					cfg.win2.height <= hi_field;
				end
				default: begin
				end
			endcase
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Strobe always names a known register
	assert property (@(posedge clk) disable iff (!resetn)
		cfg_we |-> !$isunknown(cfg_addr));

	// A zero width would stall the raster counter wrap
	assert property (@(posedge clk) disable iff (!resetn)
		(cfg_we && cfg_addr == cfg_pkg::CFG_OUT_SIZE) |-> lo_field != '0);

endmodule

//--- src/video_pkg.sv
`include "blender_defs.svh"

package video_pkg;

	// Placement window of one layer
	typedef struct packed {
		logic [`IMG_WBITS-1:0] left;
		logic [`IMG_HBITS-1:0] top;
		logic [`IMG_WBITS-1:0] width;
		logic [`IMG_HBITS-1:0] height;
	} win_t;

	// ARGB background beat, alpha in the top byte
	typedef struct packed {
		logic [`BG_PIXEL_WIDTH-1:0] data;
		logic                       user;
		logic                       last;
	} bg_beat_t;

	// Grey overlay beat
	typedef struct packed {
		logic [`OV_PIXEL_WIDTH-1:0] data;
		logic                       user;
		logic                       last;
	} ov_beat_t;

	typedef struct packed {
		logic [`OUT_PIXEL_WIDTH-1:0] data;
		logic                        user;
		logic                        last;
	} out_beat_t;

endpackage

//--- src/window_shifter.sv
`timescale 1ns/1ps
`include "blender_defs.svh"

module window_shifter #(
	parameter int PIXEL_WIDTH = `BG_PIXEL_WIDTH
) (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic [`IMG_WBITS-1:0]  col,
	input  logic [`IMG_HBITS-1:0]  row,
	input  logic                   advance,
	input  video_pkg::win_t        win,
	input  logic                   s_valid,
	input  logic [PIXEL_WIDTH-1:0] s_data,
	input  logic                   s_user,
	input  logic                   s_last,
	output logic                   s_ready,
	output logic                   need,
	output logic                   hold_valid,
	output logic [PIXEL_WIDTH-1:0] data
);

	// One-beat hold register
	logic                   hold_full;
	logic [PIXEL_WIDTH-1:0] hold_data;
	logic                   hold_user;
	logic                   hold_last;

	// Ready stays low until the first cycle after reset
	logic run_q;

	logic col_in;
	logic row_in;
	logic at_origin;
	logic consume;
	logic drop;

	//////////////////////////////
	// Window test
	//////////////////////////////

	// Offset compare avoids overflow of left + width
	assign col_in    = (col >= win.left) && ((col - win.left) < win.width);
	assign row_in    = (row >= win.top) && ((row - win.top) < win.height);
	assign need      = col_in && row_in;
	assign at_origin = (col == '0) && (row == '0);

	// Held beat used for the current pixel
	assign consume = advance && need;

	// Frame resync, stale beats before the frame start are thrown away
	assign drop = need && at_origin && hold_full && !hold_user;

	assign hold_valid = hold_full && !drop;
	assign s_ready    = run_q && (!hold_full || consume || drop);
	assign data       = need ? hold_data : '0;

	//////////////////////////////
	// Hold register
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			run_q     <= 1'b0;
			hold_full <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (s_ready) begin
				hold_full <= s_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_ready && s_valid) begin
			hold_data <= s_data;
			hold_user <= s_user;
			hold_last <= s_last;
		end
	end

	//////////////////////////////
	// Checks
	//////////////////////////////

	// The blender only steps past a covered pixel once its beat is here
	assert property (@(posedge clk) disable iff (!resetn)
		(advance && need) |-> hold_full);

	// A consumed beat ends a window row exactly at the right edge
	assert property (@(posedge clk) disable iff (!resetn)
		(advance && need) |-> hold_last == ((col - win.left) == (win.width - 1'b1)));

endmodule
